/* verilog/aes_pkg.sv */
package aes_pkg;

    // One column of the state, or one word of the key schedule
    typedef logic [31:0] aes_word_t;

    // Round number, 0 for the initial AddRoundKey and 10 for the final round
    typedef logic [3:0] round_idx_t;

    // Byte 0 and column 0 sit at the most significant end (FIPS-197 order)
    typedef union packed {
        aes_word_t [0:3]       col;
        logic [0:15][7:0]      bytes;
    } aes_state_t;

    localparam round_idx_t NUM_ROUNDS = 4'd10;
    localparam int NUM_ROUND_KEYS = 11;

    // Round constant, applied to the top byte of the rotated word
    function automatic aes_word_t rcon(input round_idx_t round);
        case (round)
            4'd1:    return 32'h0100_0000;
            4'd2:    return 32'h0200_0000;
            4'd3:    return 32'h0400_0000;
            4'd4:    return 32'h0800_0000;
            4'd5:    return 32'h1000_0000;
            4'd6:    return 32'h2000_0000;
            4'd7:    return 32'h4000_0000;
            4'd8:    return 32'h8000_0000;
            4'd9:    return 32'h1b00_0000;
            4'd10:   return 32'h3600_0000;
            default: return 32'h0000_0000;
        endcase
    endfunction

    // Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        logic [7:0] shifted;
        shifted = {b[6:0], 1'b0};
        return b[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

endpackage

/* verilog/aes_sbox.sv */
`timescale 1ns/10ps

module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    // Forward substitution table, entry 0 first
    localparam logic [0:255][7:0] SBOX = {
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    assign out_byte = SBOX[in_byte];

endmodule

/* verilog/aes_key_store.sv */
`timescale 1ns/10ps

module aes_key_store import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  round_idx_t wr_addr,
    input  aes_state_t wr_key,
    input  round_idx_t rd_addr,
    output aes_state_t rd_key
);

    // Schedule stays valid between blocks so a key can be reused
    aes_state_t mem [0:NUM_ROUND_KEYS-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_ROUND_KEYS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_key;
        end
    end

    // Read in the same cycle as the address
    assign rd_key = mem[rd_addr];

endmodule

/* verilog/aes_key_expander.sv */
`timescale 1ns/10ps

module aes_key_expander import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       expand_start,
    input  aes_state_t cipher_key,
    output logic       wr_en,
    output round_idx_t wr_addr,
    output aes_state_t wr_key,
    output logic       keys_ready
);

    logic       running;
    round_idx_t round_cnt;
    aes_state_t work_key;
    aes_state_t next_key;
    aes_word_t  rot_word;
    aes_word_t  sub_word;
    logic [7:0] sub_bytes [0:3];

    // RotWord on the last word of the previous round key
    assign rot_word = {work_key.col[3][23:0], work_key.col[3][31:24]};

    // SubWord
    for (genvar i = 0; i < 4; i++) begin : g_subword
        aes_sbox u_sbox (
            .in_byte  (rot_word[31 - 8*i -: 8]),
            .out_byte (sub_bytes[i])
        );
    end

    assign sub_word = {sub_bytes[0], sub_bytes[1], sub_bytes[2], sub_bytes[3]};

    // Each new word chains off the one before it
    always_comb begin
        next_key.col[0] = work_key.col[0] ^ sub_word ^ rcon(round_cnt);
        next_key.col[1] = work_key.col[1] ^ next_key.col[0];
        next_key.col[2] = work_key.col[2] ^ next_key.col[1];
        next_key.col[3] = work_key.col[3] ^ next_key.col[2];
    end

    // Key 0 goes straight from the cipher key on the edge after expand_start
    assign wr_en      = expand_start | running;
    assign wr_addr    = running ? round_cnt : 4'd0;
    assign wr_key     = running ? next_key : cipher_key;
    assign keys_ready = running && (round_cnt == NUM_ROUNDS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running   <= 1'b0;
            round_cnt <= '0;
        end else if (expand_start) begin
            running   <= 1'b1;
            round_cnt <= 4'd1;
        end else if (running) begin
            if (round_cnt == NUM_ROUNDS) begin
                running <= 1'b0;
            end else begin
                round_cnt <= round_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (expand_start) begin
            work_key <= cipher_key;
        end else if (running) begin
            work_key <= next_key;
        end
    end

endmodule

/* verilog/aes_round_logic.sv */
`timescale 1ns/10ps

module aes_round_logic import aes_pkg::*; (
    input  aes_state_t state_in,
    input  aes_state_t round_key,
    input  logic       final_round,
    output aes_state_t state_out
);

    logic [7:0] sub_bytes [0:15];
    aes_state_t shift_st;
    aes_state_t mix_st;

    // One column times the fixed MixColumns matrix
    function automatic aes_word_t mix_column(input aes_word_t w);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // SubBytes
    for (genvar i = 0; i < 16; i++) begin : g_subbytes
        aes_sbox u_sbox (
            .in_byte  (state_in.bytes[i]),
            .out_byte (sub_bytes[i])
        );
    end

    // ShiftRows, byte index is 4*column + row and row r rotates left by r
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_st.bytes[4*c + r] = sub_bytes[4*((c + r) % 4) + r];
            end
        end
    end

    // MixColumns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mix_st.col[c] = mix_column(shift_st.col[c]);
        end
    end

    // Last round has no MixColumns
    assign state_out = (final_round ? shift_st : mix_st) ^ round_key;

endmodule

/* verilog/aes_cipher_engine.sv */
`timescale 1ns/10ps

module aes_cipher_engine import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       load_key,
    input  aes_state_t key,
    input  aes_state_t plaintext,
    output logic       expand_start,
    output aes_state_t cipher_key,
    input  logic       keys_ready,
    output round_idx_t rd_addr,
    input  aes_state_t rd_key,
    input  aes_state_t next_state,
    output aes_state_t state,
    output logic       final_round,
    output aes_state_t ciphertext,
    output logic       busy,
    output logic       done
);

    localparam logic [1:0] PH_IDLE   = 2'd0;
    localparam logic [1:0] PH_KEYS   = 2'd1;
    localparam logic [1:0] PH_ROUNDS = 2'd2;

    logic [1:0] phase;
    round_idx_t round_cnt;

    // Round counter doubles as the key store address
    assign rd_addr     = round_cnt;
    assign final_round = (phase == PH_ROUNDS) && (round_cnt == NUM_ROUNDS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase        <= PH_IDLE;
            round_cnt    <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            expand_start <= 1'b0;
            ciphertext   <= '0;
        end else begin
            done         <= 1'b0;
            expand_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    // Starts only land here, so a start during a run is dropped
                    if (start) begin
                        busy      <= 1'b1;
                        round_cnt <= '0;
                        if (load_key) begin
                            expand_start <= 1'b1;
                            phase        <= PH_KEYS;
                        end else begin
                            phase <= PH_ROUNDS;
                        end
                    end
                end
                PH_KEYS: begin
                    if (keys_ready) begin
                        phase <= PH_ROUNDS;
                    end
                end
                PH_ROUNDS: begin
                    if (round_cnt == NUM_ROUNDS) begin
                        ciphertext <= next_state;
                        done       <= 1'b1;
                        busy       <= 1'b0;
                        phase      <= PH_IDLE;
                        round_cnt  <= '0;
                    end else begin
                        round_cnt <= round_cnt + 4'd1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Data path registers
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && start) begin
            state <= plaintext;
            if (load_key) begin
                cipher_key <= key;
            end
        end else if (phase == PH_ROUNDS) begin
            // Round 0 is the initial AddRoundKey
            state <= (round_cnt == 4'd0) ? (state ^ rd_key) : next_state;
        end
    end

endmodule

/* verilog/aes_top.sv */
`timescale 1ns/10ps

module aes_top import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       load_key,
    input  aes_state_t key,
    input  aes_state_t plaintext,
    output aes_state_t ciphertext,
    output logic       busy,
    output logic       done
);

    logic       expand_start;
    aes_state_t cipher_key;
    logic       keys_ready;
    logic       wr_en;
    round_idx_t wr_addr;
    aes_state_t wr_key;
    round_idx_t rd_addr;
    aes_state_t rd_key;
    aes_state_t cur_state;
    aes_state_t next_state;
    logic       final_round;

    aes_cipher_engine u_engine (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .load_key     (load_key),
        .key          (key),
        .plaintext    (plaintext),
        .expand_start (expand_start),
        .cipher_key   (cipher_key),
        .keys_ready   (keys_ready),
        .rd_addr      (rd_addr),
        .rd_key       (rd_key),
        .next_state   (next_state),
        .state        (cur_state),
        .final_round  (final_round),
        .ciphertext   (ciphertext),
        .busy         (busy),
        .done         (done)
    );

    aes_key_expander u_expander (
        .clk          (clk),
        .reset        (reset),
        .expand_start (expand_start),
        .cipher_key   (cipher_key),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_key       (wr_key),
        .keys_ready   (keys_ready)
    );

    aes_key_store u_key_store (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_key  (wr_key),
        .rd_addr (rd_addr),
        .rd_key  (rd_key)
    );

    aes_round_logic u_round (
        .state_in    (cur_state),
        .round_key   (rd_key),
        .final_round (final_round),
        .state_out   (next_state)
    );

endmodule

/* tests/aes_vectors.svh */
`ifndef AES_VECTORS_SVH
`define AES_VECTORS_SVH

// Known-answer vectors, one key / plaintext / ciphertext triple each

// FIPS-197 Appendix B
localparam logic [127:0] B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam logic [127:0] B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
localparam logic [127:0] B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;

// FIPS-197 Appendix C.1
localparam logic [127:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
localparam logic [127:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;
localparam logic [127:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

// All-zero key and plaintext
localparam logic [127:0] Z_KEY  = 128'h0;
localparam logic [127:0] Z_PT   = 128'h0;
localparam logic [127:0] Z_CT   = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

`endif

/* tests/aes_tb.sv */
`timescale 1ns/10ps

module aes_tb import aes_pkg::*; ();

    `include "aes_vectors.svh"

    // Starts issued, plus the quiet window after the aborted run
    localparam int NUM_TRANSACTIONS = 11;
    localparam int WATCHDOG_NS      = NUM_TRANSACTIONS * 30 * 10 + 200;
    localparam int FRESH_LATENCY    = 22;
    localparam int REUSE_LATENCY    = 11;
    localparam int RUN_LIMIT        = 30;

    logic       clk = 1'b0;
    logic       reset;
    logic       start;
    logic       load_key;
    aes_state_t key;
    aes_state_t plaintext;
    aes_state_t ciphertext;
    logic       busy;
    logic       done;

    int         error_count;
    int         done_count;
    int         expected_dones;
    logic       prev_done;
    aes_state_t prev_ct;

    aes_top uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .load_key   (load_key),
        .key        (key),
        .plaintext  (plaintext),
        .ciphertext (ciphertext),
        .busy       (busy),
        .done       (done)
    );

    always #5 clk = ~clk;

    // Outputs are sampled at the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            assert (!busy && !done && ciphertext == '0) else begin
                error_count++;
                $display("ERROR busy/done/ciphertext in reset: busy %h done %h ciphertext %h",
                         busy, done, ciphertext);
            end
        end else begin
            assert (!(done && prev_done)) else begin
                error_count++;
                $display("done stayed high for more than one cycle");
            end
            assert (!(done && busy)) else begin
                error_count++;
                $display("ERROR busy with done high: expected %h got %h", 1'b0, busy);
            end
            // Ciphertext only moves on a completion
            assert (done || ciphertext == prev_ct) else begin
                error_count++;
                $display("ERROR ciphertext changed without done: expected %h got %h",
                         prev_ct, ciphertext);
            end
            if (done) begin
                done_count++;
            end
        end
        prev_done = done;
        prev_ct   = ciphertext;
    end

    // One start, then wait for done and check latency, busy and result
    task automatic run_block(input logic [127:0] k, input logic [127:0] pt,
                             input logic [127:0] exp_ct, input logic lk,
                             input int exp_latency, input string name);
        int n;
        bit seen;
        n    = 0;
        seen = 0;
        @(posedge clk);
        start     <= 1'b1;
        load_key  <= lk;
        key       <= k;
        plaintext <= pt;
        @(posedge clk);
        start <= 1'b0;
        expected_dones++;
        // n counts the full cycles after the start edge with done still low
        while (!seen && n < RUN_LIMIT) begin
            @(negedge clk);
            if (done) begin
                seen = 1;
            end else begin
                n++;
                assert (busy) else begin
                    error_count++;
                    $display("ERROR busy (%s) cycle %0d: expected %h got %h",
                             name, n, 1'b1, busy);
                end
            end
        end
        assert (seen) else begin
            error_count++;
            $display("Run %s never raised done within %0d cycles", name, RUN_LIMIT);
        end
        if (seen) begin
            assert (n == exp_latency) else begin
                error_count++;
                $display("ERROR done latency (%s): expected %h got %h", name, exp_latency, n);
            end
            assert (ciphertext == exp_ct) else begin
                error_count++;
                $display("ERROR ciphertext (%s): expected %h got %h", name, exp_ct, ciphertext);
            end
        end
    endtask

    // Second start with other data while a run is in flight
    task automatic inject_start();
        repeat (6) @(posedge clk);
        start     <= 1'b1;
        load_key  <= 1'b1;
        key       <= C1_KEY;
        plaintext <= C1_PT;
        @(posedge clk);
        start <= 1'b0;
    endtask

    initial begin
        int dones_before;
        reset          = 1'b1;
        start          = 1'b0;
        load_key       = 1'b0;
        key            = '0;
        plaintext      = '0;
        error_count    = 0;
        done_count     = 0;
        expected_dones = 0;
        prev_done      = 1'b0;
        prev_ct        = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!busy && !done && ciphertext == '0) else begin
            error_count++;
            $display("ERROR outputs after reset: busy %h done %h ciphertext %h",
                     busy, done, ciphertext);
        end

        run_block(B_KEY, B_PT, B_CT, 1'b1, FRESH_LATENCY, "B fresh");
        run_block(Z_KEY, Z_PT, Z_CT, 1'b1, FRESH_LATENCY, "zero fresh");
        run_block(C1_KEY, C1_PT, C1_CT, 1'b1, FRESH_LATENCY, "C.1 fresh");

        // Stored schedule, the key port is ignored
        run_block(Z_KEY, C1_PT, C1_CT, 1'b0, REUSE_LATENCY, "C.1 reuse");
        run_block(B_KEY, B_PT, B_CT, 1'b1, FRESH_LATENCY, "B reload");
        run_block(Z_KEY, B_PT, B_CT, 1'b0, REUSE_LATENCY, "B reuse");

        fork
            run_block(Z_KEY, Z_PT, Z_CT, 1'b1, FRESH_LATENCY, "zero with late start");
            inject_start();
        join

        // Abort a run with reset, nothing may complete afterwards
        @(posedge clk);
        start     <= 1'b1;
        load_key  <= 1'b1;
        key       <= B_KEY;
        plaintext <= B_PT;
        @(posedge clk);
        start <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        dones_before = done_count;
        repeat (RUN_LIMIT) @(posedge clk);
        assert (done_count == dones_before) else begin
            error_count++;
            $display("A done pulse appeared after reset aborted the run");
        end
        run_block(C1_KEY, C1_PT, C1_CT, 1'b1, FRESH_LATENCY, "C.1 after reset");

        @(negedge clk);
        assert (done_count == expected_dones) else begin
            error_count++;
            $display("ERROR done pulse count: expected %h got %h", expected_dones, done_count);
        end
        $display("Errors: %0d, done pulses: %0d of %0d", error_count, done_count,
                 expected_dones);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Errors: %0d, done pulses: %0d of %0d", error_count + 1, done_count,
                 expected_dones);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+tests
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_key_store.sv
verilog/aes_key_expander.sv
verilog/aes_round_logic.sv
verilog/aes_cipher_engine.sv
verilog/aes_top.sv
tests/aes_tb.sv
